//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

   ///////////////////////////////////////////////////////////////////////
   // Micro-operation opcodes
   ///////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      uopNop,                       // No operation
      uopRead,                      // Memory read
      uopWrite,                     // Memory write
      uopWrApr,                     // Load APR level/enable/flags
      uopWrPi,                      // Load PI enables and system-on
      uopPiAck,                     // Start servicing requested level
      uopPiDismiss,                 // End highest level in progress
      uopHalt                       // Stop the CPU
   } uopCode_t;

   ///////////////////////////////////////////////////////////////////////
   // APR flag indices in the 4-bit flag vector
   ///////////////////////////////////////////////////////////////////////

   localparam int aprFlagCsl   = 0;  // Console interrupt
   localparam int aprFlagNxm   = 1;  // Non-existent memory
   localparam int aprFlagTimer = 2;  // Interval timer
   localparam int aprFlagSoft  = 3;  // Software flag, also to console

   // uopData layout for uopWrApr
   localparam int aprLevelLo  = 0;   // 3-bit PI level
   localparam int aprEnableLo = 3;   // 4-bit enable mask
   localparam int aprClearLo  = 7;   // 4-bit clear mask
   localparam int aprSetLo    = 11;  // 4-bit set mask

   // uopData layout for uopWrPi
   localparam int piEnableLo = 0;    // Bit k-1 enables level k
   localparam int piSysOnBit = 7;    // System-on

   ///////////////////////////////////////////////////////////////////////
   // cpuAddr layout
   ///////////////////////////////////////////////////////////////////////

   // Address itself sits in bits 17:0
   localparam int addrWriteBit = 18; // Write cycle
   localparam int addrPriLo    = 19; // Current PI priority, 3 bits

endpackage

`default_nettype wire

//--- logic/consoleIntf.sv
`default_nettype none
`timescale 1ns/1ns

module consoleIntf (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    cslSet,     // One-cycle load strobe
   input  wire                    cslRun,
   input  wire                    cslCont,
   input  wire                    cslExec,
   input  wire                    uopValid,
   input  wire cpuPkg::uopCode_t  uop,
   input  wire                    busBusy,    // Bus cycle in flight
   output logic                   uopGo,
   output logic                   cpuRun,
   output logic                   cpuExec,
   output logic                   cpuCont,
   output logic                   cpuHalt
);

   // Single execute decision for every block
   assign uopGo = uopValid && cpuRun && !busBusy;

   ///////////////////////////////////////////////////////////////////////
   // Console status registers
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         cpuRun  <= 1'b0;
         cpuExec <= 1'b0;
         cpuCont <= 1'b0;
         cpuHalt <= 1'b1;                    // Come up halted
      end else if (cslSet) begin
         // Console load wins over a halt in the same cycle
         cpuRun  <= cslRun;
         cpuExec <= cslExec;
         cpuCont <= cslCont;
         if (cslRun) begin
            cpuHalt <= 1'b0;                 // Leaving halt
         end
      end else if (uopGo && uop == cpuPkg::uopHalt) begin
         cpuRun  <= 1'b0;                    // Stop accepting uops
         cpuHalt <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- logic/intervalTimer.sv
`default_nettype none
`timescale 1ns/1ns

module intervalTimer #(
   parameter int tickCycles = 4,             // Clocks per tick
   parameter int intrTicks  = 8              // Ticks per interrupt
) (
   input  wire         clk,
   input  wire         reset,
   input  wire         timerEn,
   output logic [17:0] timerCount,          // Wraps at 2^18
   output logic        timerIntr            // One-cycle pulse
);

   localparam int preW = (tickCycles > 1) ? $clog2(tickCycles) : 1;

   logic [preW-1:0] preCount;                // Prescaler
   logic            tick;
   logic [17:0]     nextCount;

   // Last prescaler state, only while enabled
   assign tick      = timerEn && (preCount == preW'(tickCycles - 1));
   assign nextCount = timerCount + 18'd1;

   always_ff @(posedge clk) begin
      if (reset) begin
         preCount   <= '0;
         timerCount <= '0;
         timerIntr  <= 1'b0;
      end else begin
         timerIntr <= 1'b0;
         if (tick) begin
            preCount   <= '0;
            timerCount <= nextCount;
            // Interrupt on each nonzero intrTicks boundary
            timerIntr  <= (nextCount != 18'd0) &&
                          (nextCount % 18'(intrTicks) == 18'd0);
         end else if (timerEn) begin
            preCount <= preCount + 1'b1;     // Holds when disabled
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/aprFlags.sv
`default_nettype none
`timescale 1ns/1ns

module aprFlags (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    uopGo,
   input  wire cpuPkg::uopCode_t  uop,
   input  wire [35:0]             uopData,
   input  wire                    cslIntr,     // Level from console
   input  wire                    nxmIntr,     // Pulse from bus
   input  wire                    timerIntr,   // Pulse from timer
   output logic [6:0]             aprIntr,     // One-hot PI request
   output logic                   cslIntrO
);

   logic [3:0] aprFlag;                      // Sticky flags
   logic [3:0] aprEnable;
   logic [2:0] aprLevel;                     // 0 means no request
   logic [3:0] hwSet;                        // Hardware flag sources
   logic       wrApr;

   always_comb begin
      hwSet                       = '0;
      hwSet[cpuPkg::aprFlagCsl]   = cslIntr;
      hwSet[cpuPkg::aprFlagNxm]   = nxmIntr;
      hwSet[cpuPkg::aprFlagTimer] = timerIntr;
   end

   assign wrApr = uopGo && (uop == cpuPkg::uopWrApr);

   ///////////////////////////////////////////////////////////////////////
   // Flag, enable and level registers
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         aprFlag   <= '0;
         aprEnable <= '0;
         aprLevel  <= '0;
      end else if (wrApr) begin
         aprLevel  <= uopData[cpuPkg::aprLevelLo +: 3];
         aprEnable <= uopData[cpuPkg::aprEnableLo +: 4];
         // Clear first, then set mask and sources on top
         aprFlag   <= (aprFlag & ~uopData[cpuPkg::aprClearLo +: 4]) |
                      uopData[cpuPkg::aprSetLo +: 4] | hwSet;
      end else begin
         aprFlag <= aprFlag | hwSet;
      end
   end

   // Request at the programmed level when any enabled flag is up
   always_comb begin
      aprIntr = '0;
      if ((|(aprFlag & aprEnable)) && (aprLevel != 3'd0)) begin
         aprIntr[aprLevel - 3'd1] = 1'b1;    // Level k on bit k-1
      end
   end

   assign cslIntrO = aprFlag[cpuPkg::aprFlagSoft];

endmodule

`default_nettype wire

//--- logic/priorityIntr.sv
`default_nettype none
`timescale 1ns/1ns

module priorityIntr (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    uopGo,
   input  wire cpuPkg::uopCode_t  uop,
   input  wire [35:0]             uopData,
   input  wire [6:0]              aprIntr,    // Bit k-1 is level k
   input  wire [6:0]              ubaIntr,
   output logic [2:0]             piReqPri,   // 0 when none
   output logic [2:0]             piCurPri,   // 0 when none
   output logic                   piIntr
);

   logic [6:0] piEnable;                     // Per-level enables
   logic       piSysOn;
   logic [6:0] piActive;                     // Levels in progress
   logic [6:0] piReq;

   // Lowest-numbered set bit as a level, level 1 is highest priority
   function automatic logic [2:0] lowestLevel(input logic [6:0] vec);
      logic [2:0] lvl;
      lvl = 3'd0;
      for (int i = 6; i >= 0; i--) begin
         if (vec[i]) begin
            lvl = 3'(i + 1);                 // Lower bits overwrite
         end
      end
      return lvl;
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // Request arbitration
   ///////////////////////////////////////////////////////////////////////

   assign piReq    = (ubaIntr | aprIntr) & piEnable & {7{piSysOn}};
   assign piReqPri = lowestLevel(piReq);
   assign piCurPri = lowestLevel(piActive);

   // Only a strictly higher priority breaks in
   assign piIntr = (piReqPri != 3'd0) &&
                   ((piCurPri == 3'd0) || (piReqPri < piCurPri));

   ///////////////////////////////////////////////////////////////////////
   // Enable and in-progress registers
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         piEnable <= '0;
         piSysOn  <= 1'b0;
         piActive <= '0;
      end else if (uopGo) begin
         case (uop)
            cpuPkg::uopWrPi: begin
               piEnable <= uopData[cpuPkg::piEnableLo +: 7];
               piSysOn  <= uopData[cpuPkg::piSysOnBit];
            end
            cpuPkg::uopPiAck: begin
               if (piReqPri != 3'd0) begin
                  piActive[piReqPri - 3'd1] <= 1'b1;   // Enter level
               end
            end
            cpuPkg::uopPiDismiss: begin
               if (piCurPri != 3'd0) begin
                  piActive[piCurPri - 3'd1] <= 1'b0;   // Leave level
               end
            end
            default: ;                       // Not a PI uop
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/busCycle.sv
`default_nettype none
`timescale 1ns/1ns

module busCycle #(
   parameter int nxmTimeout = 6              // Clocks to wait for ack
) (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    uopGo,
   input  wire cpuPkg::uopCode_t  uop,
   input  wire [17:0]             uopAddr,
   input  wire [35:0]             uopData,
   input  wire [2:0]              piCurPri,
   input  wire                    cpuAck,
   input  wire [35:0]             cpuDataIn,
   output logic                   cpuReq,
   output logic [35:0]            cpuAddr,    // Address, write, priority
   output logic [35:0]            cpuData,
   output logic [35:0]            busData,    // Last read data
   output logic                   busBusy,
   output logic                   busDone,    // End of cycle pulse
   output logic                   nxmIntr     // Timeout pulse
);

   typedef enum logic {
      stIdle,
      stWait                                 // Request out, waiting ack
   } busState_t;

   localparam int toW = $clog2(nxmTimeout + 1);

   busState_t        state;
   logic [toW-1:0]   waitCount;              // Clocks in stWait
   logic             start;
   logic [35:0]      addrNext;

   assign start = uopGo && (uop == cpuPkg::uopRead || uop == cpuPkg::uopWrite);

   // Bus address word as presented with the request
   always_comb begin
      addrNext                              = '0;
      addrNext[17:0]                        = uopAddr;
      addrNext[cpuPkg::addrWriteBit]        = (uop == cpuPkg::uopWrite);
      addrNext[cpuPkg::addrPriLo +: 3]      = piCurPri;
   end

   assign cpuReq  = (state == stWait);
   assign busBusy = (state == stWait);       // Blocks further uops

   ///////////////////////////////////////////////////////////////////////
   // Request sequencing and NXM timeout
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= stIdle;
         waitCount <= '0;
         busDone   <= 1'b0;
         nxmIntr   <= 1'b0;
      end else begin
         busDone <= 1'b0;
         nxmIntr <= 1'b0;
         case (state)
            stIdle: begin
               waitCount <= '0;
               if (start) begin
                  state <= stWait;
               end
            end
            stWait: begin
               if (cpuAck) begin
                  state   <= stIdle;
                  busDone <= 1'b1;
               end else if (waitCount == toW'(nxmTimeout - 1)) begin
                  state   <= stIdle;         // Nobody answered
                  busDone <= 1'b1;
                  nxmIntr <= 1'b1;
               end else begin
                  waitCount <= waitCount + 1'b1;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   // Payload held steady for the whole request
   always_ff @(posedge clk) begin
      if (state == stIdle && start) begin
         cpuAddr <= addrNext;
         cpuData <= uopData;
      end
      if (state == stWait && cpuAck && !cpuAddr[cpuPkg::addrWriteBit]) begin
         busData <= cpuDataIn;               // Read data capture
      end
   end

endmodule

`default_nettype wire

//--- logic/cpu.sv
`default_nettype none
`timescale 1ns/1ns

module cpu #(
   parameter int tickCycles = 4,       // Clocks per timer tick
   parameter int intrTicks  = 8,       // Ticks per timer interrupt
   parameter int nxmTimeout = 6        // Clocks to wait for bus ack
) (
   input  wire                    clk,
   input  wire                    reset,
   // Console
   input  wire                    cslSet,       // Load run/exec/cont
   input  wire                    cslRun,
   input  wire                    cslCont,
   input  wire                    cslExec,
   input  wire                    cslTimerEn,
   input  wire                    cslIntrI,     // Console to CPU
   output wire                    cslIntrO,     // CPU to console
   // UBA
   input  wire [6:0]              ubaIntr,
   // Micro-operation strobe
   input  wire                    uopValid,
   input  wire cpuPkg::uopCode_t  uop,
   input  wire [17:0]             uopAddr,
   input  wire [35:0]             uopData,
   // Bus
   output wire                    cpuReq,
   input  wire                    cpuAck,
   output wire [35:0]             cpuAddr,      // Address and flags
   output wire [35:0]             cpuData,
   input  wire [35:0]             cpuDataIn,
   output wire [35:0]             busData,      // Captured read data
   output wire                    busBusy,
   output wire                    busDone,
   // Status
   output wire                    cpuHalt,
   output wire                    cpuRun,
   output wire                    cpuExec,
   output wire                    cpuCont,
   output wire                    piIntr,
   output wire [2:0]              piReqPri,
   output wire [2:0]              piCurPri,
   output wire [17:0]             timerCount
);

   wire       uopGo;                   // Execute strobe to all blocks
   wire       nxmIntr;
   wire       timerIntr;
   wire [6:0] aprIntr;                 // APR one-hot PI request

   ///////////////////////////////////////////////////////////////////////
   // Console interface and execute gate
   ///////////////////////////////////////////////////////////////////////

   consoleIntf consoleIntf_inst (
      .clk      (clk),
      .reset    (reset),
      .cslSet   (cslSet),
      .cslRun   (cslRun),
      .cslCont  (cslCont),
      .cslExec  (cslExec),
      .uopValid (uopValid),
      .uop      (uop),
      .busBusy  (busBusy),
      .uopGo    (uopGo),
      .cpuRun   (cpuRun),
      .cpuExec  (cpuExec),
      .cpuCont  (cpuCont),
      .cpuHalt  (cpuHalt)
   );

   intervalTimer #(
      .tickCycles (tickCycles),
      .intrTicks  (intrTicks)
   ) intervalTimer_inst (
      .clk        (clk),
      .reset      (reset),
      .timerEn    (cslTimerEn),
      .timerCount (timerCount),
      .timerIntr  (timerIntr)
   );

   aprFlags aprFlags_inst (
      .clk       (clk),
      .reset     (reset),
      .uopGo     (uopGo),
      .uop       (uop),
      .uopData   (uopData),
      .cslIntr   (cslIntrI),
      .nxmIntr   (nxmIntr),
      .timerIntr (timerIntr),
      .aprIntr   (aprIntr),
      .cslIntrO  (cslIntrO)            // Soft flag back to console
   );

   priorityIntr priorityIntr_inst (
      .clk      (clk),
      .reset    (reset),
      .uopGo    (uopGo),
      .uop      (uop),
      .uopData  (uopData),
      .aprIntr  (aprIntr),
      .ubaIntr  (ubaIntr),
      .piReqPri (piReqPri),
      .piCurPri (piCurPri),
      .piIntr   (piIntr)
   );

   // Memory/IO bus with NXM detect
   busCycle #(
      .nxmTimeout (nxmTimeout)
   ) busCycle_inst (
      .clk       (clk),
      .reset     (reset),
      .uopGo     (uopGo),
      .uop       (uop),
      .uopAddr   (uopAddr),
      .uopData   (uopData),
      .piCurPri  (piCurPri),
      .cpuAck    (cpuAck),
      .cpuDataIn (cpuDataIn),
      .cpuReq    (cpuReq),
      .cpuAddr   (cpuAddr),
      .cpuData   (cpuData),
      .busData   (busData),
      .busBusy   (busBusy),
      .busDone   (busDone),
      .nxmIntr   (nxmIntr)
   );

endmodule

`default_nettype wire

//--- verification/cpuTb.sv
`default_nettype none
`timescale 1ns/1ns

module cpuTb;

   localparam int          tickCycles  = 4;              // cpu defaults
   localparam int          intrTicks   = 8;
   localparam logic [35:0] dataPattern = 36'hA5C396E17;  // Read data scrambler
   localparam logic [17:0] nxmBase     = 18'h20000;      // No memory from here up

   // Status bits are {run, halt, exec, cont, piIntr, cslIntrO}
   typedef struct packed {
      cpuPkg::uopCode_t uop;
      logic [17:0]      addr;
      logic [35:0]      data;
      logic [3:0]       csl;          // {run load, exec, cont, cslIntrI}
      logic [6:0]       uba;
      logic             waitBus;      // Bus cycle expected
      logic [35:0]      expBus;
      logic [5:0]       status;
      logic [2:0]       expReq;
      logic [2:0]       expCur;
   } stimRow_t;

   logic             clk;
   logic             reset;
   logic             cslSet, cslRun, cslCont, cslExec, cslTimerEn, cslIntrI;
   logic [6:0]       ubaIntr;
   logic             uopValid;
   cpuPkg::uopCode_t uop;
   logic [17:0]      uopAddr;
   logic [35:0]      uopData;
   logic             cpuAck = 1'b0;       // Driven by the responder
   logic [35:0]      cpuDataIn = '0;
   logic             cslIntrO, cpuReq, busBusy, busDone;
   logic [35:0]      cpuAddr, cpuData, busData;
   logic             cpuHalt, cpuRun, cpuExec, cpuCont, piIntr;
   logic [2:0]       piReqPri, piCurPri;
   logic [17:0]      timerCount;

   stimRow_t rows[$];
   logic     busDataKnown = 1'b0;        // Set once a read has finished
   integer   seed = 32'hccc17f62;
   int       cycleCount = 0;
   logic     ackArmed = 1'b0;
   int       ackDelay = 0;

   cpu cpu_inst (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;             // 4 ns period
   end

   // Expected read data for an address
   function automatic logic [35:0] readWord(input logic [17:0] addr);
      return {18'd0, addr} ^ dataPattern;
   endfunction

   // Pack set 14:11 clear 10:7 enable 6:3 and level 2:0 into a uopWrApr word
   function automatic logic [35:0] aprWord(input logic [2:0] level, input logic [3:0] en,
                                           input logic [3:0] clr, input logic [3:0] set);
      return {21'd0, set, clr, en, level};
   endfunction

   task automatic checkValue(input string name, input logic [35:0] got,
                             input logic [35:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("Simulation FAILED");
         $fatal(1, "Stopped at first error");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Bus responder and run limit
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      cpuAck <= 1'b0;
      if (reset || !cpuReq || cpuAck) begin
         ackArmed <= 1'b0;                                   // Idle or cycle ending
      end else if (!ackArmed) begin
         ackArmed <= 1'b1;
         ackDelay <= 1 + int'($unsigned($random(seed)) % 3);  // 1 to 3 cycles
      end else if (ackDelay > 1) begin
         ackDelay <= ackDelay - 1;
      end else if (cpuAddr[17:0] < nxmBase) begin
         cpuAck    <= 1'b1;                                  // High addresses never ack
         cpuDataIn <= readWord(cpuAddr[17:0]);
      end
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= 60 * rows.size() + 200) begin
         $display("Test timed out after %0d clock cycles", cycleCount);
         $display("Simulation FAILED");
         $fatal(1, "Timeout");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////////////////////////

   task automatic addRow(input cpuPkg::uopCode_t op, input logic [17:0] addr,
                         input logic [35:0] data, input logic [3:0] csl,
                         input logic [6:0] uba, input logic [35:0] expBus,
                         input logic [5:0] status, input logic [2:0] expReq,
                         input logic [2:0] expCur);
      stimRow_t r;
      r.uop     = op;
      r.addr    = addr;
      r.data    = data;
      r.csl     = csl;
      r.uba     = uba;
      // Bus runs only for a read or write while running
      r.waitBus = (op == cpuPkg::uopRead || op == cpuPkg::uopWrite) && status[5];
      r.expBus  = expBus;
      r.status  = status;
      r.expReq  = expReq;
      r.expCur  = expCur;
      rows.push_back(r);
   endtask

   task automatic fillTable;
      logic [35:0] rd;
      rd = readWord(18'h00123);
      // Halted, read ignored, then console run with exec
      addRow(cpuPkg::uopRead, 18'h00100, 36'h0, 4'b0000, 7'h00, 36'h0, 6'b010000, 3'd0, 3'd0);
      addRow(cpuPkg::uopNop, 18'h0, 36'h0, 4'b1100, 7'h00, 36'h0, 6'b101000, 3'd0, 3'd0);
      addRow(cpuPkg::uopRead, 18'h00123, 36'h0, 4'b0000, 7'h00, rd, 6'b101000, 3'd0, 3'd0);
      addRow(cpuPkg::uopWrite, 18'h00456, 36'h987654321, 4'b0000, 7'h00,
             rd, 6'b101000, 3'd0, 3'd0);
      addRow(cpuPkg::uopWrPi, 18'h0, 36'h0FF, 4'b0000, 7'h00, rd, 6'b101000, 3'd0, 3'd0);
      // NXM read keeps old busData
      addRow(cpuPkg::uopRead, 18'h20010, 36'h0, 4'b0000, 7'h00, rd, 6'b101000, 3'd0, 3'd0);
      addRow(cpuPkg::uopWrApr, 18'h0, aprWord(3'd3, 4'b0010, 4'b0000, 4'b0000), 4'b0000, 7'h00,
             rd, 6'b101010, 3'd3, 3'd0);
      // UBA levels 5 and 2
      addRow(cpuPkg::uopNop, 18'h0, 36'h0, 4'b0000, 7'h12, rd, 6'b101010, 3'd2, 3'd0);
      addRow(cpuPkg::uopPiAck, 18'h0, 36'h0, 4'b0000, 7'h12, rd, 6'b101000, 3'd2, 3'd2);
      addRow(cpuPkg::uopWrite, 18'h00789, 36'h01234ABCD, 4'b0000, 7'h12,
             rd, 6'b101000, 3'd2, 3'd2);
      addRow(cpuPkg::uopNop, 18'h0, 36'h0, 4'b0000, 7'h13, rd, 6'b101010, 3'd1, 3'd2);
      addRow(cpuPkg::uopPiDismiss, 18'h0, 36'h0, 4'b0000, 7'h13, rd, 6'b101010, 3'd1, 3'd0);
      // Soft flag up, then both flags cleared
      addRow(cpuPkg::uopWrApr, 18'h0, aprWord(3'd3, 4'b0010, 4'b0000, 4'b1000), 4'b0000, 7'h00,
             rd, 6'b101011, 3'd3, 3'd0);
      addRow(cpuPkg::uopWrApr, 18'h0, aprWord(3'd0, 4'b0000, 4'b1010, 4'b0000), 4'b0000, 7'h00,
             rd, 6'b101000, 3'd0, 3'd0);
      addRow(cpuPkg::uopWrApr, 18'h0, aprWord(3'd6, 4'b0001, 4'b0000, 4'b0000), 4'b0001, 7'h00,
             rd, 6'b101010, 3'd6, 3'd0);
      addRow(cpuPkg::uopHalt, 18'h0, 36'h0, 4'b0001, 7'h00, rd, 6'b011010, 3'd6, 3'd0);
      addRow(cpuPkg::uopWrApr, 18'h0, aprWord(3'd0, 4'b0000, 4'b1111, 4'b1000), 4'b0001, 7'h00,
             rd, 6'b011010, 3'd6, 3'd0);
      // Run again with cont instead of exec
      addRow(cpuPkg::uopNop, 18'h0, 36'h0, 4'b1010, 7'h00, rd, 6'b100110, 3'd6, 3'd0);
      // Timer flag at level 4, csl flag cleared
      addRow(cpuPkg::uopWrApr, 18'h0, aprWord(3'd4, 4'b0100, 4'b0001, 4'b0000), 4'b0000, 7'h00,
             rd, 6'b100100, 3'd0, 3'd0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Row sequencing
   //////////////////////////////////////////////////////////////////////

   task automatic waitBusDone(input stimRow_t r);
      logic [35:0] expAddr;
      expAddr = {14'd0, r.expCur, r.uop == cpuPkg::uopWrite, r.addr};
      do begin
         @(negedge clk);
         if (!busDone) begin
            checkValue("cpuReq", 36'(cpuReq), 36'd1);     // Up until the cycle ends
            checkValue("busBusy", 36'(busBusy), 36'd1);
            checkValue("cpuAddr", cpuAddr, expAddr);      // Held for whole request
            if (r.uop == cpuPkg::uopWrite) begin
               checkValue("cpuData", cpuData, r.data);
            end
         end
      end while (!busDone);
      checkValue("cpuReq", 36'(cpuReq), 36'd0);          // Drops with busDone
   endtask

   task automatic applyRow(input stimRow_t r);
      @(posedge clk);
      uopValid <= 1'b1;                  // One-cycle strobe
      uop      <= r.uop;
      uopAddr  <= r.addr;
      uopData  <= r.data;
      cslSet   <= r.csl[3];
      cslRun   <= r.csl[3];
      cslExec  <= r.csl[2];
      cslCont  <= r.csl[1];
      cslIntrI <= r.csl[0];
      ubaIntr  <= r.uba;
      @(posedge clk);
      uopValid <= 1'b0;
      cslSet   <= 1'b0;
      if (r.waitBus) begin
         waitBusDone(r);
      end else begin
         repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            checkValue("cpuReq", 36'(cpuReq), 36'd0);    // No bus cycle here
         end
      end
   endtask

   task automatic checkRow(input stimRow_t r);
      if (busDataKnown) begin
         checkValue("busData", busData, r.expBus);
      end
      checkValue("cpuRun", 36'(cpuRun), 36'(r.status[5]));
      checkValue("cpuHalt", 36'(cpuHalt), 36'(r.status[4]));
      checkValue("cpuExec", 36'(cpuExec), 36'(r.status[3]));
      checkValue("cpuCont", 36'(cpuCont), 36'(r.status[2]));
      checkValue("piIntr", 36'(piIntr), 36'(r.status[1]));
      checkValue("cslIntrO", 36'(cslIntrO), 36'(r.status[0]));
      checkValue("piReqPri", 36'(piReqPri), 36'(r.expReq));
      checkValue("piCurPri", 36'(piCurPri), 36'(r.expCur));
   endtask

   // Count follows enable edges divided by tickCycles
   task automatic runTimer;
      int          n;
      logic [35:0] expPri;
      checkValue("timerCount", 36'(timerCount), 36'd0);
      @(posedge clk);
      cslTimerEn <= 1'b1;                // Cycle 0 of the count
      for (n = 1; n <= intrTicks * tickCycles + 2; n++) begin
         @(posedge clk);
         @(negedge clk);
         checkValue("timerCount", 36'(timerCount), 36'(n / tickCycles));
         // Timer flag lands one clock after the count reaches intrTicks
         expPri = (n > intrTicks * tickCycles) ? 36'd4 : 36'd0;
         checkValue("piReqPri", 36'(piReqPri), expPri);
      end
      checkValue("piIntr", 36'(piIntr), 36'd1);         // Timer flag at level 4
      @(posedge clk);
      cslTimerEn <= 1'b0;
   endtask

   initial begin
      reset      = 1'b1;
      cslSet     = 1'b0;
      cslRun     = 1'b0;
      cslCont    = 1'b0;
      cslExec    = 1'b0;
      cslTimerEn = 1'b0;
      cslIntrI   = 1'b0;
      ubaIntr    = '0;
      uopValid   = 1'b0;
      uop        = cpuPkg::uopNop;
      uopAddr    = '0;
      uopData    = '0;
      fillTable();
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      checkValue("cpuHalt", 36'(cpuHalt), 36'd1);        // Reset state
      checkValue("cpuRun", 36'(cpuRun), 36'd0);
      checkValue("cpuExec", 36'(cpuExec), 36'd0);
      checkValue("cpuCont", 36'(cpuCont), 36'd0);
      checkValue("busBusy", 36'(busBusy), 36'd0);
      checkValue("piIntr", 36'(piIntr), 36'd0);
      foreach (rows[i]) begin
         applyRow(rows[i]);
         if (rows[i].waitBus) begin
            busDataKnown = 1'b1;
         end
         checkRow(rows[i]);
      end
      runTimer();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
logic/cpuPkg.sv
logic/consoleIntf.sv
logic/intervalTimer.sv
logic/aprFlags.sv
logic/priorityIntr.sv
logic/busCycle.sv
logic/cpu.sv
verification/cpuTb.sv

//--- Makefile
SIM = obj_dir/VcpuTb

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard logic/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --timescale 1ns/1ns --top-module cpuTb -f sources.f -o VcpuTb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
